//--- build.f
+incdir+.
source/erx_pkg.sv
source/erx_protocol.sv
source/erx_remap.sv
source/erx_cfg.sv
source/erx_arbiter.sv
source/erx_core.sv
test/erx_core_tb.sv

//--- erx_core_cfg.svh
`ifndef ERX_CORE_CFG_SVH
`define ERX_CORE_CFG_SVH

// Mesh coordinates of this core, compared with dstaddr[31:20]
`define ERX_ID                12'h810

// Region codes in dstaddr[19:16] for traffic aimed at this core
`define ERX_CFG_REGION        4'hF   // Own register space
`define ERX_RR_REGION         4'hE   // Read responses coming home

// Register offsets in dstaddr[5:2]
`define ERX_REG_REMAP_CTRL    4'd0   // Remap mode in bits 1:0
`define ERX_REG_REMAP_SEL     4'd1   // Upper address bit select mask
`define ERX_REG_REMAP_PATTERN 4'd2   // Replacement bits for static mode
`define ERX_REG_REMAP_BASE    4'd3   // Offset subtracted in base mode
`define ERX_REG_RX_COUNT      4'd4   // Read only packet counter

// Width of the offset field
`define ERX_REG_OFS_HI        5
`define ERX_REG_OFS_LO        2

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the erx_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module erx_core_tb

out=$(./obj_dir/Verx_core_tb)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
   exit 0
fi
exit 1

//--- source/erx_arbiter.sv
`timescale 1ns/1ps

module erx_arbiter (
   input  logic                   clk,
   input  logic                   rst_n,
   input  erx_pkg::rx_item_t      remap_item,
   input  erx_pkg::rx_item_t      cfg_item,
   input  logic                   rxwr_wait,
   input  logic                   rxrd_wait,
   input  logic                   rxrr_wait,
   output logic                   stall,
   output logic                   rxwr_access,
   output logic                   rxrd_access,
   output logic                   rxrr_access,
   output erx_pkg::emesh_packet_t rxwr_packet,
   output erx_pkg::emesh_packet_t rxrd_packet,
   output erx_pkg::emesh_packet_t rxrr_packet
);
   import erx_pkg::*;

   // Channel index 0 write, 1 read, 2 read response
   rx_item_t      sel_item;    // Whichever side path is valid
   logic [2:0]    load;        // Target channel one hot
   logic [2:0]    wait_v;
   logic [2:0]    acc_q;
   emesh_packet_t pkt_q [0:2];

   // Paths never both valid, remap side takes priority anyway
   assign sel_item = remap_item.valid ? remap_item : cfg_item;

   always_comb begin
      load = 3'b000;
      if (sel_item.valid) begin
         case (sel_item.kind)
            KIND_WRITE: load[0] = 1'b1;
            KIND_READ:  load[1] = 1'b1;
            KIND_RESP:  load[2] = 1'b1;
            default:    load    = 3'b000;   // Register access never reaches here
         endcase
      end
   end

   assign wait_v = {rxrr_wait, rxrd_wait, rxwr_wait};
   assign stall  = |(acc_q & wait_v);      // Blocked output freezes pipe

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc_q <= 3'b000;
      end else if (!stall) begin
         acc_q <= load;                    // All current outputs delivered
      end else begin
         acc_q <= acc_q & wait_v;          // Drop the ones taken this edge
      end
   end

   always_ff @(posedge clk) begin
      for (int c = 0; c < 3; c++) begin
         if (!stall && load[c]) begin
            pkt_q[c] <= sel_item.packet;
         end
      end
   end

   assign rxwr_access = acc_q[0];
   assign rxrd_access = acc_q[1];
   assign rxrr_access = acc_q[2];
   assign rxwr_packet = pkt_q[0];
   assign rxrd_packet = pkt_q[1];
   assign rxrr_packet = pkt_q[2];

endmodule

//--- source/erx_cfg.sv
`timescale 1ns/1ps
`include "erx_core_cfg.svh"

module erx_cfg (
   input  logic                clk,
   input  logic                rst_n,
   input  erx_pkg::rx_item_t   rx_item,
   input  logic                stall,
   output erx_pkg::remap_cfg_t remap_cfg,
   output erx_pkg::rx_item_t   cfg_item
);
   import erx_pkg::*;

   logic          is_cfg;      // Register access in this stage
   logic          reg_wr;
   logic          reg_rd;
   logic [3:0]    offset;      // Register index from dstaddr
   logic [31:0]   wr_data;
   logic [31:0]   rd_data;
   emesh_packet_t req;
   emesh_packet_t resp;
   remap_mode_e   mode_q;
   logic [11:0]   sel_q;
   logic [11:0]   pattern_q;
   logic [31:0]   base_q;
   logic [31:0]   count_q;     // Non register packets seen
   logic          valid_q;
   emesh_packet_t resp_q;

   assign req     = rx_item.packet;
   assign offset  = req.dstaddr[`ERX_REG_OFS_HI:`ERX_REG_OFS_LO];
   assign wr_data = req.data;
   assign is_cfg  = rx_item.valid && (rx_item.kind == KIND_CFG);
   assign reg_wr  = is_cfg && req.write && !stall;
   assign reg_rd  = is_cfg && !req.write;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mode_q    <= REMAP_OFF;
         sel_q     <= '0;
         pattern_q <= '0;
         base_q    <= '0;
         count_q   <= '0;
      end else begin
         if (reg_wr) begin
            case (offset)
               `ERX_REG_REMAP_CTRL:    mode_q    <= remap_mode_e'(wr_data[1:0]);
               `ERX_REG_REMAP_SEL:     sel_q     <= wr_data[11:0];
               `ERX_REG_REMAP_PATTERN: pattern_q <= wr_data[11:0];
               `ERX_REG_REMAP_BASE:    base_q    <= wr_data;
               default: ;                        // Counter and holes ignore writes
            endcase
         end
         if (!stall && rx_item.valid && (rx_item.kind != KIND_CFG)) begin
            count_q <= count_q + 32'd1;
         end
      end
   end

   always_comb begin
      case (offset)
         `ERX_REG_REMAP_CTRL:    rd_data = {30'b0, mode_q};
         `ERX_REG_REMAP_SEL:     rd_data = {20'b0, sel_q};
         `ERX_REG_REMAP_PATTERN: rd_data = {20'b0, pattern_q};
         `ERX_REG_REMAP_BASE:    rd_data = base_q;
         `ERX_REG_RX_COUNT:      rd_data = count_q;
         default:                rd_data = '0;  // Unmapped reads as zero
      endcase
   end

   // Response goes back to the requester as a write
   always_comb begin
      resp          = '0;
      resp.write    = 1'b1;
      resp.datamode = req.datamode;
      resp.ctrlmode = req.ctrlmode;
      resp.dstaddr  = req.srcaddr;
      resp.data     = rd_data;
      resp.srcaddr  = req.dstaddr;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (!stall) begin
         valid_q <= reg_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall && reg_rd) begin
         resp_q <= resp;
      end
   end

   assign remap_cfg = '{mode: mode_q, sel: sel_q, pattern: pattern_q, base: base_q};
   assign cfg_item  = '{valid: valid_q, kind: KIND_WRITE, packet: resp_q};

endmodule

//--- source/erx_core.sv
`timescale 1ns/1ps

module erx_core (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   rx_access,
   input  erx_pkg::emesh_packet_t rx_packet,
   output logic                   rx_wr_wait,
   output logic                   rx_rd_wait,
   output logic                   rxwr_access,
   output erx_pkg::emesh_packet_t rxwr_packet,
   input  logic                   rxwr_wait,
   output logic                   rxrd_access,
   output erx_pkg::emesh_packet_t rxrd_packet,
   input  logic                   rxrd_wait,
   output logic                   rxrr_access,
   output erx_pkg::emesh_packet_t rxrr_packet,
   input  logic                   rxrr_wait
);
   import erx_pkg::*;

   rx_item_t   rx_item;        // Classified input packet
   rx_item_t   remap_item;     // Ordinary traffic after remap
   rx_item_t   cfg_item;       // Register read responses
   remap_cfg_t remap_cfg;
   logic       stall;

   erx_protocol i_protocol (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx_access (rx_access),
      .rx_packet (rx_packet),
      .stall     (stall),
      .rx_item   (rx_item)
   );

   erx_remap i_remap (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx_item    (rx_item),
      .remap_cfg  (remap_cfg),
      .stall      (stall),
      .remap_item (remap_item)
   );

   erx_cfg i_cfg (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx_item   (rx_item),
      .stall     (stall),
      .remap_cfg (remap_cfg),
      .cfg_item  (cfg_item)
   );

   erx_arbiter i_arbiter (
      .clk         (clk),
      .rst_n       (rst_n),
      .remap_item  (remap_item),
      .cfg_item    (cfg_item),
      .rxwr_wait   (rxwr_wait),
      .rxrd_wait   (rxrd_wait),
      .rxrr_wait   (rxrr_wait),
      .stall       (stall),
      .rxwr_access (rxwr_access),
      .rxrd_access (rxrd_access),
      .rxrr_access (rxrr_access),
      .rxwr_packet (rxwr_packet),
      .rxrd_packet (rxrd_packet),
      .rxrr_packet (rxrr_packet)
   );

   assign rx_wr_wait = stall;      // Same stall for both directions
   assign rx_rd_wait = stall;

endmodule

//--- source/erx_pkg.sv
package erx_pkg;

   // Mesh packet, write flag sits in bit 0
   typedef struct packed {
      logic [31:0] srcaddr;   // Bits 103:72
      logic [31:0] data;      // Bits 71:40
      logic [31:0] dstaddr;   // Bits 39:8
      logic        spare;     // Bit 7, unused
      logic [3:0]  ctrlmode;  // Bits 6:3
      logic [1:0]  datamode;  // Bits 2:1
      logic        write;     // Bit 0
   } emesh_packet_t;

   // Packet class decided in the protocol stage
   typedef enum logic [1:0] {
      KIND_WRITE = 2'd0,      // Ordinary write
      KIND_READ  = 2'd1,      // Ordinary read
      KIND_RESP  = 2'd2,      // Read response
      KIND_CFG   = 2'd3       // Own register access
   } rx_kind_e;

   // Classified packet moving between stages
   typedef struct packed {
      logic          valid;
      rx_kind_e      kind;
      emesh_packet_t packet;
   } rx_item_t;

   // Address remap modes
   typedef enum logic [1:0] {
      REMAP_OFF    = 2'd0,    // Address passes unchanged
      REMAP_STATIC = 2'd1,    // Masked replace of bits 31:20
      REMAP_BASE   = 2'd2     // Subtract base address
   } remap_mode_e;

   // Remap settings from register block
   typedef struct packed {
      remap_mode_e mode;
      logic [11:0] sel;
      logic [11:0] pattern;
      logic [31:0] base;
   } remap_cfg_t;

endpackage

//--- source/erx_protocol.sv
`timescale 1ns/1ps
`include "erx_core_cfg.svh"

module erx_protocol (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   rx_access,
   input  erx_pkg::emesh_packet_t rx_packet,
   input  logic                   stall,
   output erx_pkg::rx_item_t      rx_item
);
   import erx_pkg::*;

   logic          accept;      // Packet taken this edge
   logic          to_me;       // Address carries our core id
   logic [3:0]    region;      // Region code of dstaddr
   rx_kind_e      kind;        // Class of incoming packet
   logic          valid_q;
   rx_kind_e      kind_q;
   emesh_packet_t packet_q;

   assign accept = rx_access & ~stall;
   assign to_me  = (rx_packet.dstaddr[31:20] == `ERX_ID);
   assign region = rx_packet.dstaddr[19:16];

   // Own regions first, everything else by write flag
   always_comb begin
      if (to_me && (region == `ERX_RR_REGION)) begin
         kind = KIND_RESP;
      end else if (to_me && (region == `ERX_CFG_REGION)) begin
         kind = KIND_CFG;
      end else if (rx_packet.write) begin
         kind = KIND_WRITE;
      end else begin
         kind = KIND_READ;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (!stall) begin
         valid_q <= rx_access;            // Empty slot when sender idle
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         kind_q   <= kind;
         packet_q <= rx_packet;
      end
   end

   assign rx_item = '{valid: valid_q, kind: kind_q, packet: packet_q};

endmodule

//--- source/erx_remap.sv
`timescale 1ns/1ps

module erx_remap (
   input  logic                clk,
   input  logic                rst_n,
   input  erx_pkg::rx_item_t   rx_item,
   input  erx_pkg::remap_cfg_t remap_cfg,
   input  logic                stall,
   output erx_pkg::rx_item_t   remap_item
);
   import erx_pkg::*;

   logic [31:0]   addr;        // Incoming destination
   logic [31:0]   addr_new;    // Remapped destination
   logic          is_rdwr;     // Ordinary write or read
   logic          keep;        // Item continues down this path
   emesh_packet_t packet_nxt;
   logic          valid_q;
   rx_kind_e      kind_q;
   emesh_packet_t packet_q;

   assign addr    = rx_item.packet.dstaddr;
   assign is_rdwr = (rx_item.kind == KIND_WRITE) || (rx_item.kind == KIND_READ);
   assign keep    = rx_item.valid && (rx_item.kind != KIND_CFG);   // Register access leaves here

   always_comb begin
      case (remap_cfg.mode)
         REMAP_OFF: begin
            addr_new = addr;
         end
         REMAP_STATIC: begin
            addr_new = {(addr[31:20] & ~remap_cfg.sel) |
                        (remap_cfg.pattern & remap_cfg.sel), addr[19:0]};
         end
         REMAP_BASE: begin
            addr_new = addr - remap_cfg.base;     // Wraps below base
         end
         default: begin
            addr_new = addr;                     // Reserved mode acts as off
         end
      endcase
   end

   always_comb begin
      packet_nxt = rx_item.packet;
      if (is_rdwr) begin
         packet_nxt.dstaddr = addr_new;          // Responses untouched
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (!stall) begin
         valid_q <= keep;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall && keep) begin
         kind_q   <= rx_item.kind;
         packet_q <= packet_nxt;
      end
   end

   assign remap_item = '{valid: valid_q, kind: kind_q, packet: packet_q};

endmodule

//--- test/erx_core_tb.sv
`timescale 1ns/1ps
`include "erx_core_cfg.svh"

module erx_core_tb;
   import erx_pkg::*;

   localparam int N_ROWS  = 40;
   localparam int N_QUIET = 20;   // Rows run with all waits low

   typedef struct packed {
      rx_kind_e    kind;
      logic        write;
      logic [31:0] dst;
      logic [31:0] data;
      logic [31:0] src;
      logic [1:0]  exp_chan;       // 0 rxwr, 1 rxrd, 2 rxrr, 3 none
      logic [31:0] exp_dst;
      logic [31:0] exp_data;
   } row_t;

   typedef struct packed {
      emesh_packet_t pkt;
      int            cyc;          // Delivery cycle or -1 if untimed
   } exp_t;

   logic          clk;
   logic          rst_n;
   logic          rx_access;
   emesh_packet_t rx_packet;
   logic          rx_wr_wait;
   logic          rx_rd_wait;
   logic          rxwr_access;
   logic          rxrd_access;
   logic          rxrr_access;
   emesh_packet_t rxwr_packet;
   emesh_packet_t rxrd_packet;
   emesh_packet_t rxrr_packet;
   logic          rxwr_wait;
   logic          rxrd_wait;
   logic          rxrr_wait;

   row_t          rows [N_ROWS];
   int            n_rows = 0;
   exp_t          q_wr[$];
   exp_t          q_rd[$];
   exp_t          q_rr[$];
   logic          held [3];      // Output was blocked last cycle
   emesh_packet_t held_pkt [3];
   int            cyc = 0;
   int            errors = 0;
   int            checks = 0;

   // Reference register state in table order
   logic [1:0]    m_mode = 2'd0;
   logic [11:0]   m_sel = '0;
   logic [11:0]   m_pat = '0;
   logic [31:0]   m_base = '0;
   logic [31:0]   m_count = '0;

   erx_core i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet),
      .rx_wr_wait  (rx_wr_wait),
      .rx_rd_wait  (rx_rd_wait),
      .rxwr_access (rxwr_access),
      .rxwr_packet (rxwr_packet),
      .rxwr_wait   (rxwr_wait),
      .rxrd_access (rxrd_access),
      .rxrd_packet (rxrd_packet),
      .rxrd_wait   (rxrd_wait),
      .rxrr_access (rxrr_access),
      .rxrr_packet (rxrr_packet),
      .rxrr_wait   (rxrr_wait)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [31:0] cfg_addr(input logic [3:0] ofs);
      return {`ERX_ID, `ERX_CFG_REGION, 10'h0, ofs, 2'b00};
   endfunction

   function automatic logic [31:0] rr_addr(input logic [15:0] low);
      return {`ERX_ID, `ERX_RR_REGION, low};
   endfunction

   function automatic string chan_name(input int c);
      return (c == 0) ? "rxwr" : (c == 1) ? "rxrd" : "rxrr";
   endfunction

   function automatic int queue_size(input int c);
      return (c == 0) ? q_wr.size() : (c == 1) ? q_rd.size() : q_rr.size();
   endfunction

   function automatic logic [31:0] remap_addr(input logic [31:0] a);
      logic [31:0] r;
      r = a;
      case (m_mode)
         2'd1: begin
            for (int b = 0; b < 12; b++) begin
               if (m_sel[b]) begin
                  r[20 + b] = m_pat[b];   // Selected upper bit takes pattern
               end
            end
         end
         2'd2: r = a - m_base;           // Base
         default: ;
      endcase
      return r;
   endfunction

   function automatic logic [31:0] reg_value(input logic [3:0] ofs);
      case (ofs)
         4'd0: return {30'b0, m_mode};
         4'd1: return {20'b0, m_sel};
         4'd2: return {20'b0, m_pat};
         4'd3: return m_base;
         4'd4: return m_count;
         default: return 32'h0;        // Holes read as zero
      endcase
   endfunction

   // Appends a row and works out where it should land
   task automatic add_row(input rx_kind_e kind, input logic write, input logic [31:0] dst,
                          input logic [31:0] data, input logic [31:0] src);
      row_t r;
      r = '{kind: kind, write: write, dst: dst, data: data, src: src,
            exp_chan: 2'd3, exp_dst: dst, exp_data: data};
      if (kind == KIND_CFG && write) begin
         case (dst[5:2])
            4'd0: m_mode = data[1:0];
            4'd1: m_sel = data[11:0];
            4'd2: m_pat = data[11:0];
            4'd3: m_base = data;
            default: ;                 // Counter is read only
         endcase
      end else if (kind == KIND_CFG) begin
         r.exp_chan = 2'd0;            // Response returns as a write
         r.exp_dst  = src;
         r.exp_data = reg_value(dst[5:2]);
      end else begin
         r.exp_chan = (kind == KIND_WRITE) ? 2'd0 : (kind == KIND_READ) ? 2'd1 : 2'd2;
         r.exp_dst  = (kind == KIND_RESP) ? dst : remap_addr(dst);
         m_count    = m_count + 32'd1;
      end
      rows[n_rows] = r;
      n_rows++;
   endtask

   task automatic build_table();
      int          k;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] s;
      add_row(KIND_WRITE, 1'b1, 32'h1230_0040, 32'hdead_0001, 32'h8200_0100);
      add_row(KIND_READ,  1'b0, 32'h4560_0080, 32'h0000_0000, 32'h8200_0104);
      add_row(KIND_RESP,  1'b1, rr_addr(16'h0010), 32'hcafe_0002, 32'h4560_0080);
      add_row(KIND_CFG,   1'b0, cfg_addr(`ERX_REG_REMAP_CTRL), 32'h0, 32'h4440_0000);
      add_row(KIND_CFG,   1'b1, cfg_addr(`ERX_REG_REMAP_SEL), 32'h0000_0f00, 32'h0);
      add_row(KIND_CFG,   1'b1, cfg_addr(`ERX_REG_REMAP_PATTERN), 32'h0000_0a50, 32'h0);
      add_row(KIND_CFG,   1'b1, cfg_addr(`ERX_REG_REMAP_CTRL), 32'h0000_0001, 32'h0);
      add_row(KIND_WRITE, 1'b1, 32'h1234_5678, 32'hdead_0003, 32'h8200_0108);
      add_row(KIND_READ,  1'b0, 32'h9870_0004, 32'h0000_0000, 32'h8200_010c);
      add_row(KIND_RESP,  1'b1, rr_addr(16'h0020), 32'hcafe_0004, 32'h9870_0004);
      add_row(KIND_CFG,   1'b0, cfg_addr(`ERX_REG_REMAP_SEL), 32'h0, 32'h4440_0004);
      add_row(KIND_CFG,   1'b0, cfg_addr(`ERX_REG_RX_COUNT), 32'h0, 32'h4440_0008);
      add_row(KIND_CFG,   1'b1, cfg_addr(`ERX_REG_REMAP_BASE), 32'h1000_0000, 32'h0);
      add_row(KIND_CFG,   1'b1, cfg_addr(`ERX_REG_REMAP_CTRL), 32'h0000_0002, 32'h0);
      add_row(KIND_WRITE, 1'b1, 32'h3000_0010, 32'hdead_0005, 32'h8200_0110);
      add_row(KIND_READ,  1'b0, 32'h0800_0000, 32'h0000_0000, 32'h8200_0114);  // Wraps
      add_row(KIND_CFG,   1'b0, cfg_addr(`ERX_REG_REMAP_BASE), 32'h0, 32'h4440_000c);
      add_row(KIND_CFG,   1'b1, cfg_addr(`ERX_REG_RX_COUNT), 32'h5555_5555, 32'h0);
      add_row(KIND_CFG,   1'b0, cfg_addr(`ERX_REG_RX_COUNT), 32'h0, 32'h4440_0010);
      add_row(KIND_CFG,   1'b0, cfg_addr(4'd7), 32'h0, 32'h4440_0014);  // Unused offset
      for (int i = N_QUIET; i < N_ROWS; i++) begin
         k = $urandom_range(3);
         a = $urandom & 32'h7fff_ffff;   // Keeps clear of own core id
         d = $urandom;
         s = $urandom;
         case (k)
            0: add_row(KIND_WRITE, 1'b1, a, d, s);
            1: add_row(KIND_READ, 1'b0, a, d, s);
            2: add_row(KIND_RESP, 1'b1, rr_addr(a[15:0]), d, s);
            default: add_row(KIND_CFG, 1'b0, cfg_addr(`ERX_REG_RX_COUNT), d, s);
         endcase
      end
   endtask

   function automatic emesh_packet_t make_packet(input int i);
      emesh_packet_t p;
      p = '{srcaddr: rows[i].src, data: rows[i].data, dstaddr: rows[i].dst, spare: 1'b0,
            ctrlmode: i[3:0], datamode: i[1:0], write: rows[i].write};
      return p;
   endfunction

   task automatic push_expected(input int i, input int when);
      exp_t e;
      e.pkt         = make_packet(i);
      e.pkt.dstaddr = rows[i].exp_dst;
      e.pkt.data    = rows[i].exp_data;
      if (rows[i].kind == KIND_CFG) begin
         e.pkt.write   = 1'b1;
         e.pkt.srcaddr = rows[i].dst;    // Requested address comes back as source
      end
      e.cyc = (i < N_QUIET) ? when + 3 : -1;
      case (rows[i].exp_chan)
         2'd0: q_wr.push_back(e);
         2'd1: q_rd.push_back(e);
         2'd2: q_rr.push_back(e);
         default: ;                      // Register writes produce no output
      endcase
   endtask

   task automatic set_waits(input logic rnd);
      rxwr_wait = rnd && ($urandom_range(3) == 0);
      rxrd_wait = rnd && ($urandom_range(3) == 0);
      rxrr_wait = rnd && ($urandom_range(3) == 0);
   endtask

   task automatic check_low(input string name, input logic v);
      assert (v === 1'b0) else begin
         $display("[FAIL] %0t %s exp 0 got %b", $time, name, v);
         errors++;
      end
   endtask

   // Holds the row on the port until the core takes it
   task automatic apply_row(input int i);
      logic done;
      done = 1'b0;
      while (!done) begin
         @(posedge clk);
         #10;
         set_waits(i >= N_QUIET);
         rx_access = 1'b1;
         rx_packet = make_packet(i);
         #40;
         assert (rx_rd_wait == rx_wr_wait) else begin
            $display("[FAIL] %0t rx_rd_wait exp %b got %b", $time, rx_wr_wait, rx_rd_wait);
            errors++;
         end
         if (!rx_wr_wait) begin
            push_expected(i, cyc);
            done = 1'b1;
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #10;
         rx_access = 1'b0;
         set_waits(1'b0);
      end
   endtask

   task automatic check_channel(input int c, input logic acc, input logic wt,
                                input emesh_packet_t pkt);
      exp_t e;
      if (held[c]) begin
         assert (acc && (pkt == held_pkt[c])) else begin
            $display("[FAIL] %0t %s_packet moved under wait: held %h now %h",
                     $time, chan_name(c), held_pkt[c], pkt);
            errors++;
         end
      end
      held[c]     = acc && wt;
      held_pkt[c] = pkt;
      if (acc && !wt) begin
         assert (queue_size(c) != 0) else begin
            $display("Unexpected packet on %s at %0t: %h", chan_name(c), $time, pkt);
            errors++;
         end
         if (queue_size(c) != 0) begin
            case (c)
               0: e = q_wr.pop_front();
               1: e = q_rd.pop_front();
               default: e = q_rr.pop_front();
            endcase
            checks++;
            assert (pkt == e.pkt) else begin
               $display("[FAIL] %0t %s_packet exp %h got %h", $time, chan_name(c), e.pkt, pkt);
               errors++;
            end
            if (e.cyc >= 0) begin
               assert (cyc == e.cyc) else begin
                  $display("[FAIL] %0t %s_access cycle exp %0d got %0d",
                           $time, chan_name(c), e.cyc, cyc);
                  errors++;
               end
            end
         end
      end
   endtask

   // Samples mid cycle away from the drive point
   always @(posedge clk) begin
      #50;
      if (rst_n) begin
         check_channel(0, rxwr_access, rxwr_wait, rxwr_packet);
         check_channel(1, rxrd_access, rxrd_wait, rxrd_packet);
         check_channel(2, rxrr_access, rxrr_wait, rxrr_packet);
      end
   end

   initial begin
      #((N_ROWS + 20) * 4 * 100);
      $display("Watchdog expired with %0d packets still expected",
               queue_size(0) + queue_size(1) + queue_size(2));
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      void'($urandom(32'hf497_759c));
      rst_n     = 1'b0;
      rx_access = 1'b0;
      rx_packet = '0;
      rxwr_wait = 1'b0;
      rxrd_wait = 1'b0;
      rxrr_wait = 1'b0;
      for (int c = 0; c < 3; c++) begin
         held[c]     = 1'b0;
         held_pkt[c] = '0;
      end
      build_table();
      repeat (4) @(posedge clk);
      #10 rst_n = 1'b1;
      #40;
      check_low("rxwr_access", rxwr_access);
      check_low("rxrd_access", rxrd_access);
      check_low("rxrr_access", rxrr_access);
      check_low("rx_wr_wait", rx_wr_wait);
      check_low("rx_rd_wait", rx_rd_wait);
      for (int i = 0; i < n_rows; i++) begin
         if (i == N_QUIET) begin
            idle_cycles(4);              // Let timed rows drain before random waits
         end
         apply_row(i);
      end
      idle_cycles(1);
      for (int w = 0; w < 20; w++) begin
         if (queue_size(0) + queue_size(1) + queue_size(2) == 0) begin
            break;
         end
         @(posedge clk);                 // Pipeline empties in a few cycles with waits low
      end
      idle_cycles(5);                    // Catch stray late packets
      assert (queue_size(0) + queue_size(1) + queue_size(2) == 0) else begin
         $display("Scoreboard queues not empty at end of run");
         errors++;
      end
      $display("Rows %0d, packets checked %0d, errors %0d", n_rows, checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule
